// File: Bender.yml
package:
  name: dbg_monitor

sources:
  - common/dbg_pkg.sv
  - rtl/dbg_trigger_ctrl.sv
  - probe/stage_probe.sv
  - rtl/dbg_watchpoint.sv
  - apb/dbg_apb_regs.sv
  - rtl/dbg_monitor_top.sv
  - target: test
    files:
      - testbench/tb_dbg_monitor.sv

// File: apb/dbg_apb_regs.sv
`timescale 1ns/1ps

module dbg_apb_regs #(
  parameter int CNT_W = 32
) (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        psel_i,
  input  logic                                        penable_i,
  input  logic                                        pwrite_i,
  input  logic [7:0]                                  paddr_i,
  input  logic [31:0]                                 pwdata_i,
  output logic [31:0]                                 prdata_o,
  output logic                                        pslverr_o,
  input  dbg_pkg::dbg_state_e                         state_i,
  input  logic [dbg_pkg::NUM_STAGES-1:0][1:0]         stage_flags_i,
  input  logic [dbg_pkg::NUM_STAGES-1:0][CNT_W-1:0]   xfer_cnt_i,
  input  logic [dbg_pkg::NUM_STAGES-1:0][CNT_W-1:0]   stall_cnt_i,
  input  logic [31:0]                                 watch_data_i,
  input  logic                                        watch_hit_i,
  input  logic                                        feat_hit_i,
  output logic                                        cmd_valid_o,
  output dbg_pkg::dbg_cmd_e                           cmd_o,
  output logic [13:0]                                 watch_addr_o,
  output logic [3:0]                                  watch_lane_o,
  output logic [15:0]                                 feat_limit_o
);

  logic        access;
  logic        wr_en;
  logic        mapped;
  logic        read_only;
  logic [31:0] rdata;
  logic [1:0]  stage_sel_q;

  assign access = psel_i && penable_i;
  assign wr_en  = access && pwrite_i && !pslverr_o;

  always_comb begin
    rdata     = '0;
    mapped    = 1'b1;
    read_only = 1'b0;
    case (paddr_i)
      dbg_pkg::REG_ID: begin
        rdata     = dbg_pkg::DBG_ID;
        read_only = 1'b1;
      end
      dbg_pkg::REG_CTRL: begin
        rdata = '0; // Commands are write-only pulses
      end
      dbg_pkg::REG_STATUS: begin
        rdata     = {14'b0, feat_hit_i, watch_hit_i, stage_flags_i, 6'b0, state_i};
        read_only = 1'b1;
      end
      dbg_pkg::REG_WATCH_ADDR: rdata = {18'b0, watch_addr_o};
      dbg_pkg::REG_WATCH_LANE: rdata = {28'b0, watch_lane_o};
      dbg_pkg::REG_WATCH_DATA: begin
        rdata     = watch_data_i;
        read_only = 1'b1;
      end
      dbg_pkg::REG_STAGE_SEL: rdata = {30'b0, stage_sel_q};
      dbg_pkg::REG_XFER_CNT: begin
        rdata     = 32'(xfer_cnt_i[stage_sel_q]);
        read_only = 1'b1;
      end
      dbg_pkg::REG_STALL_CNT: begin
        rdata     = 32'(stall_cnt_i[stage_sel_q]);
        read_only = 1'b1;
      end
      dbg_pkg::REG_FEAT_LIMIT: rdata = {16'b0, feat_limit_o};
      default: mapped = 1'b0;
    endcase
  end

  assign pslverr_o = access && (!mapped || (pwrite_i && read_only));
  assign prdata_o  = (access && !pwrite_i) ? rdata : '0;

  assign cmd_valid_o = wr_en && (paddr_i == dbg_pkg::REG_CTRL);
  assign cmd_o       = dbg_pkg::dbg_cmd_e'(pwdata_i[1:0]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      watch_addr_o <= '0;
      watch_lane_o <= '0;
      stage_sel_q  <= '0;
      feat_limit_o <= dbg_pkg::FEAT_LIMIT_RST;
    end else if (wr_en) begin
      case (paddr_i)
        dbg_pkg::REG_WATCH_ADDR: watch_addr_o <= pwdata_i[13:0];
        dbg_pkg::REG_WATCH_LANE: watch_lane_o <= pwdata_i[3:0];
        dbg_pkg::REG_STAGE_SEL:  stage_sel_q  <= pwdata_i[1:0];
        dbg_pkg::REG_FEAT_LIMIT: feat_limit_o <= pwdata_i[15:0];
        default: begin
        end
      endcase
    end
  end

  // Access phase only ever follows a selected setup phase
  a_penable_psel: assert property (
    @(posedge clk) disable iff (!rst_n)
    penable_i |-> psel_i
  );

endmodule

// File: common/dbg_pkg.sv
package dbg_pkg;

  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_ARMED   = 2'd1,
    ST_RUN     = 2'd2,
    ST_STOPPED = 2'd3
  } dbg_state_e;

  typedef enum logic [1:0] {
    CMD_NOP   = 2'd0,
    CMD_ARM   = 2'd1,
    CMD_STOP  = 2'd2,
    CMD_CLEAR = 2'd3
  } dbg_cmd_e;

  parameter int NUM_STAGES = 4;

  // Stage order inside the probe arrays and the STATUS flag field
  parameter logic [1:0] STG_SPMM = 2'd0;
  parameter logic [1:0] STG_DMVM = 2'd1;
  parameter logic [1:0] STG_SM   = 2'd2;
  parameter logic [1:0] STG_AGGR = 2'd3;

  parameter logic [7:0] REG_ID         = 8'h00;
  parameter logic [7:0] REG_CTRL       = 8'h04;
  parameter logic [7:0] REG_STATUS     = 8'h08;
  parameter logic [7:0] REG_WATCH_ADDR = 8'h0C;
  parameter logic [7:0] REG_WATCH_LANE = 8'h10;
  parameter logic [7:0] REG_WATCH_DATA = 8'h14;
  parameter logic [7:0] REG_STAGE_SEL  = 8'h18;
  parameter logic [7:0] REG_XFER_CNT   = 8'h1C;
  parameter logic [7:0] REG_STALL_CNT  = 8'h20;
  parameter logic [7:0] REG_FEAT_LIMIT = 8'h24;

  parameter logic [31:0] DBG_ID = 32'h4E47_0001;

  // Start of the reserved feature buffer region
  parameter logic [15:0] FEAT_LIMIT_RST = 16'd43328;

endpackage

// File: flist.f
common/dbg_pkg.sv
rtl/dbg_trigger_ctrl.sv
probe/stage_probe.sv
rtl/dbg_watchpoint.sv
apb/dbg_apb_regs.sv
rtl/dbg_monitor_top.sv
testbench/tb_dbg_monitor.sv

// File: probe/stage_probe.sv
`timescale 1ns/1ps

module stage_probe #(
  parameter int CNT_W = 32
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             vld_i,
  input  logic             rdy_i,
  input  logic             run_en_i,
  input  logic             clr_i,
  output logic [1:0]       flags_o,
  output logic [CNT_W-1:0] xfer_cnt_o,
  output logic [CNT_W-1:0] stall_cnt_o
);

  logic xfer_inc;
  logic stall_inc;

  assign xfer_inc  = run_en_i && vld_i && rdy_i;
  assign stall_inc = run_en_i && vld_i && !rdy_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_o     <= '0;
      xfer_cnt_o  <= '0;
      stall_cnt_o <= '0;
    end else if (clr_i) begin
      flags_o     <= '0;
      xfer_cnt_o  <= '0;
      stall_cnt_o <= '0;
    end else begin
      if (run_en_i) begin
        flags_o <= flags_o | {rdy_i, vld_i}; // Bit 0 valid seen, bit 1 ready seen
      end
      if (xfer_inc && (xfer_cnt_o != '1)) begin
        xfer_cnt_o <= xfer_cnt_o + 1'b1; // Holds at all ones
      end
      if (stall_inc && (stall_cnt_o != '1)) begin
        stall_cnt_o <= stall_cnt_o + 1'b1;
      end
    end
  end

  // A stage either transfers or stalls in one cycle, so at most one counter moves
  a_one_counter: assert property (
    @(posedge clk) disable iff (!rst_n)
    !clr_i |=> !((xfer_cnt_o != $past(xfer_cnt_o)) && (stall_cnt_o != $past(stall_cnt_o)))
  );

endmodule

// File: rtl/dbg_monitor_top.sv
`timescale 1ns/1ps

module dbg_monitor_top #(
  parameter int CNT_W     = 32,
  parameter int NUM_LANES = 16,
  parameter int LANE_W    = 12
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              psel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  logic [7:0]                        paddr_i,
  input  logic [31:0]                       pwdata_i,
  output logic [31:0]                       prdata_o,
  output logic                              pslverr_o,
  input  logic                              spmm_vld_i,
  input  logic                              spmm_rdy_i,
  input  logic                              dmvm_vld_i,
  input  logic                              dmvm_rdy_i,
  input  logic                              sm_vld_i,
  input  logic                              sm_rdy_i,
  input  logic                              aggr_vld_i,
  input  logic                              aggr_rdy_i,
  input  logic [NUM_LANES-1:0][LANE_W-1:0]  sppe_i,
  input  logic [13:0]                       wh_addr_i,
  input  logic                              feat_ena_i,
  input  logic [15:0]                       feat_addr_i
);

  localparam int NS = dbg_pkg::NUM_STAGES;

  logic                      cmd_valid;
  dbg_pkg::dbg_cmd_e         cmd;
  dbg_pkg::dbg_state_e       state;
  logic                      run_en;
  logic                      clr;
  logic [13:0]               watch_addr;
  logic [3:0]                watch_lane;
  logic [15:0]               feat_limit;
  logic [LANE_W-1:0]         watch_data;
  logic                      watch_hit;
  logic                      feat_hit;
  logic [NS-1:0]             stage_vld;
  logic [NS-1:0]             stage_rdy;
  logic [NS-1:0][1:0]        stage_flags;
  logic [NS-1:0][CNT_W-1:0]  xfer_cnt;
  logic [NS-1:0][CNT_W-1:0]  stall_cnt;

  assign stage_vld[dbg_pkg::STG_SPMM] = spmm_vld_i;
  assign stage_rdy[dbg_pkg::STG_SPMM] = spmm_rdy_i;
  assign stage_vld[dbg_pkg::STG_DMVM] = dmvm_vld_i;
  assign stage_rdy[dbg_pkg::STG_DMVM] = dmvm_rdy_i;
  assign stage_vld[dbg_pkg::STG_SM]   = sm_vld_i;
  assign stage_rdy[dbg_pkg::STG_SM]   = sm_rdy_i;
  assign stage_vld[dbg_pkg::STG_AGGR] = aggr_vld_i;
  assign stage_rdy[dbg_pkg::STG_AGGR] = aggr_rdy_i;

  dbg_trigger_ctrl u_trigger (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .spmm_vld_i  (spmm_vld_i),
    .state_o     (state),
    .run_en_o    (run_en),
    .clr_o       (clr)
  );

  for (genvar g = 0; g < NS; g++) begin : g_probe
    stage_probe #(.CNT_W(CNT_W)) u_probe (
      .clk         (clk),
      .rst_n       (rst_n),
      .vld_i       (stage_vld[g]),
      .rdy_i       (stage_rdy[g]),
      .run_en_i    (run_en),
      .clr_i       (clr),
      .flags_o     (stage_flags[g]),
      .xfer_cnt_o  (xfer_cnt[g]),
      .stall_cnt_o (stall_cnt[g])
    );
  end

  dbg_watchpoint #(.NUM_LANES(NUM_LANES), .LANE_W(LANE_W)) u_watch (
    .clk          (clk),
    .rst_n        (rst_n),
    .run_en_i     (run_en),
    .clr_i        (clr),
    .spmm_rdy_i   (spmm_rdy_i),
    .sppe_i       (sppe_i),
    .wh_addr_i    (wh_addr_i),
    .watch_addr_i (watch_addr),
    .watch_lane_i (watch_lane),
    .feat_ena_i   (feat_ena_i),
    .feat_addr_i  (feat_addr_i),
    .feat_limit_i (feat_limit),
    .watch_data_o (watch_data),
    .watch_hit_o  (watch_hit),
    .feat_hit_o   (feat_hit)
  );

  dbg_apb_regs #(.CNT_W(CNT_W)) u_regs (
    .clk           (clk),
    .rst_n         (rst_n),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (paddr_i),
    .pwdata_i      (pwdata_i),
    .prdata_o      (prdata_o),
    .pslverr_o     (pslverr_o),
    .state_i       (state),
    .stage_flags_i (stage_flags),
    .xfer_cnt_i    (xfer_cnt),
    .stall_cnt_i   (stall_cnt),
    .watch_data_i  (32'(watch_data)), // Lane value zero-extended to the bus width
    .watch_hit_i   (watch_hit),
    .feat_hit_i    (feat_hit),
    .cmd_valid_o   (cmd_valid),
    .cmd_o         (cmd),
    .watch_addr_o  (watch_addr),
    .watch_lane_o  (watch_lane),
    .feat_limit_o  (feat_limit)
  );

endmodule

// File: rtl/dbg_trigger_ctrl.sv
`timescale 1ns/1ps

module dbg_trigger_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                cmd_valid_i,
  input  dbg_pkg::dbg_cmd_e   cmd_i,
  input  logic                spmm_vld_i,
  output dbg_pkg::dbg_state_e state_o,
  output logic                run_en_o,
  output logic                clr_o
);

  dbg_pkg::dbg_state_e state_q;
  dbg_pkg::dbg_state_e state_d;

  always_comb begin
    state_d = state_q;
    if (state_q == dbg_pkg::ST_ARMED && spmm_vld_i) begin
      state_d = dbg_pkg::ST_RUN; // First sparse multiply valid after arming
    end
    if (cmd_valid_i) begin
      case (cmd_i)
        dbg_pkg::CMD_ARM: begin
          if (state_q == dbg_pkg::ST_IDLE || state_q == dbg_pkg::ST_STOPPED) begin
            state_d = dbg_pkg::ST_ARMED;
          end
        end
        dbg_pkg::CMD_STOP: begin
          if (state_q == dbg_pkg::ST_ARMED || state_q == dbg_pkg::ST_RUN) begin
            state_d = dbg_pkg::ST_STOPPED;
          end
        end
        dbg_pkg::CMD_CLEAR: begin
          state_d = dbg_pkg::ST_IDLE;
        end
        default: begin
          state_d = state_d; // NOP keeps whatever the trigger decided
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= dbg_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o  = state_q;
  assign run_en_o = (state_q == dbg_pkg::ST_RUN);
  assign clr_o    = cmd_valid_i && (cmd_i == dbg_pkg::CMD_CLEAR); // Probes clear at this same edge

  // A clear must never leave the monitor collecting
  a_clr_not_run: assert property (
    @(posedge clk) disable iff (!rst_n)
    clr_o |=> (state_o != dbg_pkg::ST_RUN)
  );

endmodule

// File: rtl/dbg_watchpoint.sv
`timescale 1ns/1ps

module dbg_watchpoint #(
  parameter int NUM_LANES = 16,
  parameter int LANE_W    = 12
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              run_en_i,
  input  logic                              clr_i,
  input  logic                              spmm_rdy_i,
  input  logic [NUM_LANES-1:0][LANE_W-1:0]  sppe_i,
  input  logic [13:0]                       wh_addr_i,
  input  logic [13:0]                       watch_addr_i,
  input  logic [3:0]                        watch_lane_i,
  input  logic                              feat_ena_i,
  input  logic [15:0]                       feat_addr_i,
  input  logic [15:0]                       feat_limit_i,
  output logic [LANE_W-1:0]                 watch_data_o,
  output logic                              watch_hit_o,
  output logic                              feat_hit_o
);

  logic addr_match;
  logic feat_over;

  assign addr_match = run_en_i && spmm_rdy_i && (wh_addr_i == watch_addr_i);
  assign feat_over  = run_en_i && feat_ena_i && (feat_addr_i >= feat_limit_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      watch_data_o <= '0;
      watch_hit_o  <= 1'b0;
      feat_hit_o   <= 1'b0;
    end else if (clr_i) begin
      watch_data_o <= '0;
      watch_hit_o  <= 1'b0;
      feat_hit_o   <= 1'b0;
    end else begin
      if (addr_match) begin
        watch_data_o <= sppe_i[watch_lane_i]; // Latest match wins
        watch_hit_o  <= 1'b1;
      end
      if (feat_over) begin
        feat_hit_o <= 1'b1;
      end
    end
  end

  // The lane register is programmed over APB and must name an existing lane
  a_lane_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    run_en_i |-> (int'(watch_lane_i) < NUM_LANES)
  );

endmodule

// File: testbench/tb_dbg_monitor.sv
`timescale 1ns/1ps

module tb_dbg_monitor;

  localparam int TIMEOUT = 50;

  logic              clk;
  logic              rst_n;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [7:0]        paddr;
  logic [31:0]       pwdata;
  logic [31:0]       prdata;
  logic              pslverr;
  logic [3:0]        vld;
  logic [3:0]        rdy;
  logic [15:0][11:0] sppe;
  logic [13:0]       wh_addr;
  logic              feat_ena;
  logic [15:0]       feat_addr;

  integer              seed;
  int                  errors;
  logic                ctrl_wr;
  dbg_pkg::dbg_state_e ref_state;
  dbg_pkg::dbg_state_e ref_next;
  logic [3:0][1:0]     ref_flags;
  logic [31:0]         ref_xfer [4];
  logic [31:0]         ref_stall [4];

  dbg_monitor_top uut (
    .clk (clk), .rst_n (rst_n),
    .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite), .paddr_i (paddr),
    .pwdata_i (pwdata), .prdata_o (prdata), .pslverr_o (pslverr),
    .spmm_vld_i (vld[dbg_pkg::STG_SPMM]), .spmm_rdy_i (rdy[dbg_pkg::STG_SPMM]),
    .dmvm_vld_i (vld[dbg_pkg::STG_DMVM]), .dmvm_rdy_i (rdy[dbg_pkg::STG_DMVM]),
    .sm_vld_i (vld[dbg_pkg::STG_SM]), .sm_rdy_i (rdy[dbg_pkg::STG_SM]),
    .aggr_vld_i (vld[dbg_pkg::STG_AGGR]), .aggr_rdy_i (rdy[dbg_pkg::STG_AGGR]),
    .sppe_i (sppe), .wh_addr_i (wh_addr), .feat_ena_i (feat_ena), .feat_addr_i (feat_addr)
  );

  always #4 clk = ~clk;

  assign ctrl_wr = psel && penable && pwrite && (paddr == dbg_pkg::REG_CTRL);

  always_comb begin
    ref_next = ref_state;
    if (ref_state == dbg_pkg::ST_ARMED && vld[dbg_pkg::STG_SPMM]) begin
      ref_next = dbg_pkg::ST_RUN;
    end
    if (ctrl_wr) begin
      case (pwdata[1:0])
        dbg_pkg::CMD_ARM: begin
          if (ref_state == dbg_pkg::ST_IDLE || ref_state == dbg_pkg::ST_STOPPED) begin
            ref_next = dbg_pkg::ST_ARMED;
          end
        end
        dbg_pkg::CMD_STOP: begin
          if (ref_state == dbg_pkg::ST_ARMED || ref_state == dbg_pkg::ST_RUN) begin
            ref_next = dbg_pkg::ST_STOPPED;
          end
        end
        dbg_pkg::CMD_CLEAR: ref_next = dbg_pkg::ST_IDLE;
        default: begin
        end
      endcase
    end
  end

  // Expected per-stage flags and counters, counted only while collecting
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ref_state <= dbg_pkg::ST_IDLE;
      ref_flags <= '0;
      ref_xfer  <= '{default: '0};
      ref_stall <= '{default: '0};
    end else begin
      ref_state <= ref_next;
      for (int s = 0; s < 4; s++) begin
        if (ctrl_wr && pwdata[1:0] == dbg_pkg::CMD_CLEAR) begin
          ref_flags[s] <= '0;
          ref_xfer[s]  <= '0;
          ref_stall[s] <= '0;
        end else if (ref_state == dbg_pkg::ST_RUN) begin
          ref_flags[s] <= ref_flags[s] | {rdy[s], vld[s]};
          if (vld[s] && rdy[s]) begin
            ref_xfer[s] <= ref_xfer[s] + 1;
          end
          if (vld[s] && !rdy[s]) begin
            ref_stall[s] <= ref_stall[s] + 1;
          end
        end
      end
    end
  end

  a_err_in_access: assert property (
    @(posedge clk) disable iff (!rst_n) pslverr |-> (psel && penable)
  ) else begin
    errors++;
    $display("PSLVERR was raised outside an APB access phase");
  end

  a_ctrl_no_err: assert property (
    @(posedge clk) disable iff (!rst_n) ctrl_wr |-> !pslverr
  ) else begin
    errors++;
    $display("A write to CTRL was answered with PSLVERR");
  end

  task automatic finish_run();
    $display("Run complete with %0d error(s)", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic step_clock();
    @(posedge clk);
    #1;
  endtask

  task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    step_clock();
    penable = 1'b1;
    @(negedge clk);
    rdata = prdata; // Sampled mid-cycle of the access phase
    err   = pslverr;
    step_clock(); // The zero-wait slave completes the access at this edge
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_read_back(input string name, input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_transfer(1'b1, addr, data, rd, err);
    apb_transfer(1'b0, addr, '0, rd, err);
    check_value(name, data, rd);
  endtask

  task automatic wait_state(input dbg_pkg::dbg_state_e st, input string name);
    logic [31:0] rd;
    logic        err;
    int          cnt;
    cnt = 0;
    apb_transfer(1'b0, dbg_pkg::REG_STATUS, '0, rd, err);
    while (rd[1:0] != st && cnt < TIMEOUT) begin
      apb_transfer(1'b0, dbg_pkg::REG_STATUS, '0, rd, err);
      cnt++;
    end
    if (rd[1:0] != st) begin
      errors++;
      $display("%s: the trigger never reached state %0d", name, st);
      finish_run();
    end
  endtask

  task automatic drive_traffic(input int cycles, input logic spmm_vld_ok);
    logic [31:0] r;
    for (int i = 0; i < cycles; i++) begin
      r   = $random(seed);
      vld = r[3:0];
      rdy = r[7:4];
      if (!spmm_vld_ok) begin
        vld[dbg_pkg::STG_SPMM] = 1'b0; // Keeps an armed trigger waiting
      end
      step_clock();
    end
    vld = '0;
    rdy = '0;
  endtask

  task automatic check_counts(input string name);
    logic [31:0] rd;
    logic        err;
    for (int s = 0; s < 4; s++) begin
      apb_transfer(1'b1, dbg_pkg::REG_STAGE_SEL, s, rd, err);
      apb_transfer(1'b0, dbg_pkg::REG_XFER_CNT, '0, rd, err);
      check_value($sformatf("%s xfer stage %0d", name, s), ref_xfer[s], rd);
      apb_transfer(1'b0, dbg_pkg::REG_STALL_CNT, '0, rd, err);
      check_value($sformatf("%s stall stage %0d", name, s), ref_stall[s], rd);
    end
  endtask

  function automatic logic [31:0] exp_status(input logic watch_hit, input logic feat_hit);
    return {14'b0, feat_hit, watch_hit, ref_flags, 6'b0, ref_state};
  endfunction

  task automatic start_run(input string name);
    logic [31:0] rd;
    logic        err;
    apb_transfer(1'b1, dbg_pkg::REG_CTRL, 32'(dbg_pkg::CMD_ARM), rd, err);
    drive_traffic(20, 1'b0);
    apb_transfer(1'b0, dbg_pkg::REG_STATUS, '0, rd, err);
    check_value({name, " armed"}, 32'(dbg_pkg::ST_ARMED), {30'b0, rd[1:0]});
    vld = 4'b0001;
    step_clock();
    vld = '0;
    wait_state(dbg_pkg::ST_RUN, name);
  endtask

  initial begin
    logic [31:0] rd;
    logic        err;
    logic [11:0] lane_val;
    seed      = 32'h8bc3_0eb8;
    errors    = 0;
    clk       = 1'b0;
    rst_n     = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    vld       = '0;
    rdy       = '0;
    sppe      = '0;
    wh_addr   = 14'h3FFF; // Away from any programmed watch address
    feat_ena  = 1'b0;
    feat_addr = '0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    step_clock();

    apb_transfer(1'b0, dbg_pkg::REG_ID, '0, rd, err);
    check_value("id", dbg_pkg::DBG_ID, rd);
    apb_transfer(1'b0, dbg_pkg::REG_STATUS, '0, rd, err);
    check_value("status after reset", '0, rd);
    apb_transfer(1'b0, 8'h40, '0, rd, err);
    check_value("unmapped read error", 32'd1, {31'b0, err});

    apb_transfer(1'b0, dbg_pkg::REG_FEAT_LIMIT, '0, rd, err);
    check_value("feat limit reset", {16'b0, dbg_pkg::FEAT_LIMIT_RST}, rd);
    write_read_back("watch addr", dbg_pkg::REG_WATCH_ADDR, 32'h0000_1234);
    write_read_back("watch lane", dbg_pkg::REG_WATCH_LANE, 32'h0000_0005);
    write_read_back("stage sel", dbg_pkg::REG_STAGE_SEL, 32'h0000_0002);
    write_read_back("feat limit", dbg_pkg::REG_FEAT_LIMIT, 32'h0000_7777);
    apb_transfer(1'b1, dbg_pkg::REG_XFER_CNT, 32'h1, rd, err);
    check_value("xfer cnt write error", 32'd1, {31'b0, err});

    drive_traffic(40, 1'b1);
    check_counts("pre-arm");
    apb_transfer(1'b0, dbg_pkg::REG_STATUS, '0, rd, err);
    check_value("status pre-arm", '0, rd);
    start_run("first arm");

    drive_traffic(200, 1'b1);
    check_counts("run");
    apb_transfer(1'b0, dbg_pkg::REG_STATUS, '0, rd, err);
    check_value("status run", exp_status(1'b0, 1'b0), rd);
    apb_transfer(1'b1, dbg_pkg::REG_CTRL, 32'(dbg_pkg::CMD_STOP), rd, err);
    drive_traffic(100, 1'b1);
    check_counts("stopped");
    apb_transfer(1'b0, dbg_pkg::REG_STATUS, '0, rd, err);
    check_value("status stopped", exp_status(1'b0, 1'b0), rd);

    apb_transfer(1'b1, dbg_pkg::REG_WATCH_ADDR, 32'd10, rd, err);
    apb_transfer(1'b1, dbg_pkg::REG_WATCH_LANE, 32'd2, rd, err);
    apb_transfer(1'b1, dbg_pkg::REG_FEAT_LIMIT, 32'h0000_9000, rd, err);
    start_run("re-arm");
    for (int l = 0; l < 16; l++) begin
      sppe[l] = 12'($random(seed));
    end
    lane_val = sppe[2];
    wh_addr  = 14'd10;
    rdy      = 4'b0001;
    step_clock();
    wh_addr  = 14'h3FFF;
    rdy      = '0;
    apb_transfer(1'b0, dbg_pkg::REG_WATCH_DATA, '0, rd, err);
    check_value("watch data", {20'b0, lane_val}, rd);
    apb_transfer(1'b0, dbg_pkg::REG_STATUS, '0, rd, err);
    check_value("watch hit", exp_status(1'b1, 1'b0), rd);
    feat_ena  = 1'b1;
    feat_addr = 16'h8FFF;
    step_clock();
    feat_ena  = 1'b0;
    apb_transfer(1'b0, dbg_pkg::REG_STATUS, '0, rd, err);
    check_value("feat below limit", exp_status(1'b1, 1'b0), rd);
    feat_ena  = 1'b1;
    feat_addr = 16'h9000;
    step_clock();
    feat_ena  = 1'b0;
    apb_transfer(1'b0, dbg_pkg::REG_STATUS, '0, rd, err);
    check_value("feat at limit", exp_status(1'b1, 1'b1), rd);

    apb_transfer(1'b1, dbg_pkg::REG_CTRL, 32'(dbg_pkg::CMD_CLEAR), rd, err);
    apb_transfer(1'b0, dbg_pkg::REG_STATUS, '0, rd, err);
    check_value("status after clear", '0, rd);
    check_counts("clear");
    apb_transfer(1'b0, dbg_pkg::REG_WATCH_DATA, '0, rd, err);
    check_value("watch data after clear", '0, rd);
    finish_run();
  end

endmodule
